//--- rtl/operand_settings.svh
`ifndef OPERAND_SETTINGS_SVH
`define OPERAND_SETTINGS_SVH

// Width of one operand and of every register file word
`define OPERAND_WIDTH 32

// Register number width as carried by decode, execute and writeback
`define RF_ADDR_WIDTH 5

// Number of architectural registers
// Every one of them is an ordinary register, none is hardwired
`define RF_DEPTH 32

`endif

//--- rtl/fwd_pkg.sv
`default_nettype none

// Where each operand is taken from in the operand stage
package fwd_pkg;

	// Operand source select
	// Immediate is only ever chosen for operand B
	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		// Sign-extended immediate from decode
		SEL_IMM     = 2'd1,
		// Result still in the execute stage
		SEL_EX_FORW = 2'd2,
		// Result in writeback, not yet in the register file
		SEL_WB_FORW = 2'd3
	} operand_sel_e;

endpackage

`default_nettype wire

//--- rtl/pipe_pkg.sv
`default_nettype none

// Pipeline control state kept beside the operand registers
package pipe_pkg;

	// Per operand register state under the freeze rules
	typedef enum logic {
		// Register follows the mux every unfrozen cycle
		OP_TRACK = 1'b0,
		// Captured once during a decode freeze, now holding
		OP_SAVED = 1'b1
	} op_reg_state_e;

	// Both operand registers use the same encoding
	// so the two states can be compared directly

endpackage

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "operand_settings.svh"

// Two read ports, one write port
// Reads are combinational, the write lands at the clock edge
module reg_file (
	input  logic                        clk,
	input  logic                        rst_n,

	// Read port A
	input  logic [`RF_ADDR_WIDTH-1:0]   rd_addr_a,
	output logic [`OPERAND_WIDTH-1:0]   rd_data_a,

	// Read port B
	input  logic [`RF_ADDR_WIDTH-1:0]   rd_addr_b,
	output logic [`OPERAND_WIDTH-1:0]   rd_data_b,

	// Write port, driven by writeback
	input  logic                        wr_en,
	input  logic [`RF_ADDR_WIDTH-1:0]   wr_addr,
	input  logic [`OPERAND_WIDTH-1:0]   wr_data
);

	////////////////////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////////////////////

	// One word per architectural register
	logic [`OPERAND_WIDTH-1:0] mem [`RF_DEPTH];

	// All registers come out of reset as zero
	// A write is visible to the read ports from the next cycle on
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `RF_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////////////////////////////

	// No bypass of the write data here
	// Same cycle writeback values reach the operands through forwarding
	always_comb begin
		rd_data_a = mem[rd_addr_a];
	end

	// Port B is independent of port A
	always_comb begin
		rd_data_b = mem[rd_addr_b];
	end

endmodule

`default_nettype wire

//--- rtl/forward_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "operand_settings.svh"

// Forwarding controller
// Picks the source of each operand from the register numbers alone
module forward_ctrl (
	// Decoded source register numbers
	input  logic [`RF_ADDR_WIDTH-1:0] rs_a,
	input  logic [`RF_ADDR_WIDTH-1:0] rs_b,

	// Operand B takes the immediate
	input  logic                      use_imm,

	// Destination held by the execute stage
	input  logic [`RF_ADDR_WIDTH-1:0] ex_rd,
	input  logic                      ex_we,

	// Destination held by the writeback stage
	input  logic [`RF_ADDR_WIDTH-1:0] wb_rd,
	input  logic                      wb_we,

	// Selects for the operand muxes
	output fwd_pkg::operand_sel_e     sel_a,
	output fwd_pkg::operand_sel_e     sel_b
);

	import fwd_pkg::*;

	// Match of each source against each stage destination
	logic ex_hit_a;
	logic wb_hit_a;
	logic ex_hit_b;
	logic wb_hit_b;

	// A stage only forwards when it will actually write its destination
	assign ex_hit_a = ex_we && (ex_rd == rs_a);
	assign wb_hit_a = wb_we && (wb_rd == rs_a);
	assign ex_hit_b = ex_we && (ex_rd == rs_b);
	assign wb_hit_b = wb_we && (wb_rd == rs_b);

	// Shared priority for one source
	// Execute holds the younger result so it beats writeback
	function automatic operand_sel_e fwd_sel(input logic ex_hit, input logic wb_hit);
		operand_sel_e sel;
		if (ex_hit) begin
			sel = SEL_EX_FORW;
		end else if (wb_hit) begin
			sel = SEL_WB_FORW;
		end else begin
			sel = SEL_RF;
		end
		return sel;
	endfunction

	// Operand A never takes the immediate
	always_comb begin
		sel_a = fwd_sel(ex_hit_a, wb_hit_a);
	end

	// Immediate overrides any match on operand B
	always_comb begin
		if (use_imm) begin
			sel_b = SEL_IMM;
		end else begin
			sel_b = fwd_sel(ex_hit_b, wb_hit_b);
		end
	end

endmodule

`default_nettype wire

//--- rtl/operand_muxes.sv
`timescale 1ns/1ps
`default_nettype none

`include "operand_settings.svh"

// Operand source muxes and the two freeze-aware operand registers
module operand_muxes (
	input  logic                      clk,
	input  logic                      rst_n,

	// Pipeline freezes, plain levels
	input  logic                      id_freeze,
	input  logic                      ex_freeze,

	// Candidate sources
	input  logic [`OPERAND_WIDTH-1:0] rf_data_a,
	input  logic [`OPERAND_WIDTH-1:0] rf_data_b,
	input  logic [`OPERAND_WIDTH-1:0] ex_forw,
	input  logic [`OPERAND_WIDTH-1:0] wb_forw,
	input  logic [`OPERAND_WIDTH-1:0] simm,

	// Selects from the forwarding controller
	input  fwd_pkg::operand_sel_e     sel_a,
	input  fwd_pkg::operand_sel_e     sel_b,

	// Registered operands toward execute
	output logic [`OPERAND_WIDTH-1:0] operand_a,
	output logic [`OPERAND_WIDTH-1:0] operand_b
);

	import fwd_pkg::*;
	import pipe_pkg::*;

	logic [`OPERAND_WIDTH-1:0] muxed_a;
	logic [`OPERAND_WIDTH-1:0] muxed_b;
	op_reg_state_e             state_a;
	op_reg_state_e             state_b;

	////////////////////////////////////////////////////////////////////////////
	// Source muxes
	////////////////////////////////////////////////////////////////////////////

	// SEL_IMM never shows up on A, it falls to the register file
	always_comb begin
		case (sel_a)
			SEL_EX_FORW: muxed_a = ex_forw;
			SEL_WB_FORW: muxed_a = wb_forw;
			SEL_RF:      muxed_a = rf_data_a;
			default:     muxed_a = rf_data_a;
		endcase
	end

	// B adds the immediate
	always_comb begin
		case (sel_b)
			SEL_IMM:     muxed_b = simm;
			SEL_EX_FORW: muxed_b = ex_forw;
			SEL_WB_FORW: muxed_b = wb_forw;
			default:     muxed_b = rf_data_b;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Operand registers
	////////////////////////////////////////////////////////////////////////////

	// Load only while tracking and execute is not frozen
	function automatic logic op_load(input op_reg_state_e st, input logic ex_frz);
		return !ex_frz && (st == OP_TRACK);
	endfunction

	// Execute freeze holds the state as well
	// Otherwise the decode freeze alone decides saved versus tracking
	// Leaving OP_SAVED costs one cycle without a load
	function automatic op_reg_state_e op_next(input op_reg_state_e st,
			input logic id_frz, input logic ex_frz);
		if (ex_frz) begin
			return st;
		end
		return id_frz ? OP_SAVED : OP_TRACK;
	endfunction

	// Operand A
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			operand_a <= '0;
			state_a   <= OP_TRACK;
		end else begin
			if (op_load(state_a, ex_freeze)) begin
				operand_a <= muxed_a;
			end
			state_a <= op_next(state_a, id_freeze, ex_freeze);
		end
	end

	// Operand B, same rules on its own state
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			operand_b <= '0;
			state_b   <= OP_TRACK;
		end else begin
			if (op_load(state_b, ex_freeze)) begin
				operand_b <= muxed_b;
			end
			state_b <= op_next(state_b, id_freeze, ex_freeze);
		end
	end

endmodule

`default_nettype wire

//--- rtl/operand_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "operand_settings.svh"

// Operand stage top
// Register file, forwarding controller and operand registers
module operand_stage (
	input  logic                      clk,
	input  logic                      rst_n,

	// Decode side
	input  logic [`RF_ADDR_WIDTH-1:0] id_rs_a,
	input  logic [`RF_ADDR_WIDTH-1:0] id_rs_b,
	input  logic                      id_use_imm,
	input  logic [`OPERAND_WIDTH-1:0] id_simm,

	// Execute stage result
	input  logic [`RF_ADDR_WIDTH-1:0] ex_rd,
	input  logic                      ex_we,
	input  logic [`OPERAND_WIDTH-1:0] ex_result,

	// Writeback stage result, also the register file write
	input  logic [`RF_ADDR_WIDTH-1:0] wb_rd,
	input  logic                      wb_we,
	input  logic [`OPERAND_WIDTH-1:0] wb_result,

	// Freezes
	input  logic                      id_freeze,
	input  logic                      ex_freeze,

	// Operands to execute
	output logic [`OPERAND_WIDTH-1:0] operand_a,
	output logic [`OPERAND_WIDTH-1:0] operand_b
);

	import fwd_pkg::*;

	logic [`OPERAND_WIDTH-1:0] rf_data_a;
	logic [`OPERAND_WIDTH-1:0] rf_data_b;
	operand_sel_e              sel_a;
	operand_sel_e              sel_b;

	// Writeback is the only writer of the register file
	reg_file u_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr_a (id_rs_a),
		.rd_data_a (rf_data_a),
		.rd_addr_b (id_rs_b),
		.rd_data_b (rf_data_b),
		.wr_en     (wb_we),
		.wr_addr   (wb_rd),
		.wr_data   (wb_result)
	);

	// Source selection from register numbers only
	forward_ctrl u_forward_ctrl (
		.rs_a    (id_rs_a),
		.rs_b    (id_rs_b),
		.use_imm (id_use_imm),
		.ex_rd   (ex_rd),
		.ex_we   (ex_we),
		.wb_rd   (wb_rd),
		.wb_we   (wb_we),
		.sel_a   (sel_a),
		.sel_b   (sel_b)
	);

	// Data path and the registered operands
	operand_muxes u_operand_muxes (
		.clk       (clk),
		.rst_n     (rst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.rf_data_a (rf_data_a),
		.rf_data_b (rf_data_b),
		.ex_forw   (ex_result),
		.wb_forw   (wb_result),
		.simm      (id_simm),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

endmodule

`default_nettype wire

//--- tb/operand_stage_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "operand_settings.svh"

// Protocol checks on the operand registers, bound into operand_muxes
module operand_stage_asserts (
	input logic                      clk,
	input logic                      rst_n,
	input logic                      id_freeze,
	input logic                      ex_freeze,
	input fwd_pkg::operand_sel_e     sel_a,
	input pipe_pkg::op_reg_state_e   state_a,
	input pipe_pkg::op_reg_state_e   state_b,
	input logic [`OPERAND_WIDTH-1:0] operand_a,
	input logic [`OPERAND_WIDTH-1:0] operand_b
);

	import fwd_pkg::*;
	import pipe_pkg::*;

	// Number of assertion failures so far
	int unsigned fail_count = 0;

	// Immediate is a B-only source
	a_no_imm_on_a: assert property (@(posedge clk) disable iff (!rst_n)
		sel_a != SEL_IMM)
		else begin
			$error("sel_a selected the immediate");
			fail_count++;
		end

	// Execute freeze holds both operands through the next edge
	a_ex_freeze_holds: assert property (@(posedge clk) disable iff (!rst_n)
		ex_freeze |=> ($stable(operand_a) && $stable(operand_b)))
		else begin
			$error("operand changed across an execute freeze");
			fail_count++;
		end

	// Entry into OP_SAVED needs a decode freeze one cycle earlier
	a_saved_a_entry: assert property (@(posedge clk) disable iff (!rst_n)
		(state_a == OP_SAVED && $past(state_a) == OP_TRACK) |-> $past(id_freeze))
		else begin
			$error("state_a entered OP_SAVED without id_freeze");
			fail_count++;
		end

	a_saved_b_entry: assert property (@(posedge clk) disable iff (!rst_n)
		(state_b == OP_SAVED && $past(state_b) == OP_TRACK) |-> $past(id_freeze))
		else begin
			$error("state_b entered OP_SAVED without id_freeze");
			fail_count++;
		end

	// No X or Z on the operands once out of reset
	a_operands_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(operand_a) && !$isunknown(operand_b))
		else begin
			$error("operand is unknown after reset");
			fail_count++;
		end

endmodule

bind operand_muxes operand_stage_asserts u_asserts (
	.clk       (clk),
	.rst_n     (rst_n),
	.id_freeze (id_freeze),
	.ex_freeze (ex_freeze),
	.sel_a     (sel_a),
	.state_a   (state_a),
	.state_b   (state_b),
	.operand_a (operand_a),
	.operand_b (operand_b)
);

`default_nettype wire

//--- tb/operand_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "operand_settings.svh"

// Table-driven testbench for the operand stage
module operand_stage_tb;

	localparam int          W               = `OPERAND_WIDTH;
	localparam int unsigned EDGE_POLL_LIMIT = 200;

	// One stimulus row, the data words come from the LFSR
	typedef struct packed {
		logic [`RF_ADDR_WIDTH-1:0] rs_a;
		logic [`RF_ADDR_WIDTH-1:0] rs_b;
		logic                      use_imm;
		logic [`RF_ADDR_WIDTH-1:0] ex_rd;
		logic                      ex_we;
		logic [`RF_ADDR_WIDTH-1:0] wb_rd;
		logic                      wb_we;
		logic                      id_freeze;
		logic                      ex_freeze;
	} row_t;

	logic                      clk;
	logic                      rst_n;
	logic [`RF_ADDR_WIDTH-1:0] id_rs_a;
	logic [`RF_ADDR_WIDTH-1:0] id_rs_b;
	logic                      id_use_imm;
	logic [W-1:0]              id_simm;
	logic [`RF_ADDR_WIDTH-1:0] ex_rd;
	logic                      ex_we;
	logic [W-1:0]              ex_result;
	logic [`RF_ADDR_WIDTH-1:0] wb_rd;
	logic                      wb_we;
	logic [W-1:0]              wb_result;
	logic                      id_freeze;
	logic                      ex_freeze;
	logic [W-1:0]              operand_a;
	logic [W-1:0]              operand_b;

	// Reference model
	// Both registers see the same freezes, so one saved flag covers both
	logic [W-1:0] model_rf [`RF_DEPTH];
	logic [W-1:0] exp_a;
	logic [W-1:0] exp_b;
	logic         model_saved;

	int unsigned  rise_count = 0;
	realtime      last_rise;
	int           errors = 0;
	int           checks = 0;
	logic [31:0]  lfsr;
	row_t         rows[$];

	operand_stage u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.id_rs_a    (id_rs_a),
		.id_rs_b    (id_rs_b),
		.id_use_imm (id_use_imm),
		.id_simm    (id_simm),
		.ex_rd      (ex_rd),
		.ex_we      (ex_we),
		.ex_result  (ex_result),
		.wb_rd      (wb_rd),
		.wb_we      (wb_we),
		.wb_result  (wb_result),
		.id_freeze  (id_freeze),
		.ex_freeze  (ex_freeze),
		.operand_a  (operand_a),
		.operand_b  (operand_b)
	);

	// 40 ns clock
	always #20 clk = ~clk;

	// Edge bookkeeping for the wait loop
	always @(posedge clk) begin
		rise_count = rise_count + 1;
		last_rise  = $realtime;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit
	task automatic random_word(output logic [W-1:0] w);
		for (int i = 0; i < W; i++) begin
			lfsr = lfsr_next(lfsr);
			w[i] = lfsr[0];
		end
	endtask

	// Wait for the next rising edge, then settle 1 ns after it
	task automatic wait_edge;
		int unsigned target;
		int unsigned polls;
		target = rise_count + 1;
		polls  = 0;
		while (rise_count < target && polls < EDGE_POLL_LIMIT) begin
			#1;
			polls++;
		end
		if (rise_count < target) begin
			$display("Timeout: no rising clock edge within %0d ns", EDGE_POLL_LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end else begin
			#(last_rise + 1.0 - $realtime);
		end
	endtask

	// Execute beats writeback beats the register file
	function automatic logic [W-1:0] pick_source(input logic [`RF_ADDR_WIDTH-1:0] rs);
		if (ex_we && ex_rd == rs) begin
			return ex_result;
		end
		if (wb_we && wb_rd == rs) begin
			return wb_result;
		end
		return model_rf[rs];
	endfunction

	// Predict the operands after the coming edge
	task automatic model_step;
		logic [W-1:0] src_a;
		logic [W-1:0] src_b;
		src_a = pick_source(id_rs_a);
		src_b = id_use_imm ? id_simm : pick_source(id_rs_b);
		// Execute freeze holds value and state
		if (!ex_freeze) begin
			if (!model_saved) begin
				exp_a       = src_a;
				exp_b       = src_b;
				model_saved = id_freeze;
			end else if (!id_freeze) begin
				// Leaving the saved state takes a cycle with no load
				model_saved = 1'b0;
			end
		end
		if (wb_we) begin
			model_rf[wb_rd] = wb_result;
		end
	endtask

	task automatic apply_row(input row_t r);
		id_rs_a    = r.rs_a;
		id_rs_b    = r.rs_b;
		id_use_imm = r.use_imm;
		ex_rd      = r.ex_rd;
		ex_we      = r.ex_we;
		wb_rd      = r.wb_rd;
		wb_we      = r.wb_we;
		id_freeze  = r.id_freeze;
		ex_freeze  = r.ex_freeze;
		random_word(ex_result);
		random_word(wb_result);
		random_word(id_simm);
	endtask

	task automatic check_operands;
		checks++;
		assert (operand_a === exp_a) else begin
			errors++;
			$display("FAILED at %0t: operand_a expected %h, got %h", $time, exp_a, operand_a);
		end
		assert (operand_b === exp_b) else begin
			errors++;
			$display("FAILED at %0t: operand_b expected %h, got %h", $time, exp_b, operand_b);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////////////////////////////////////////

	task automatic load_table;
		// rs_a, rs_b, use_imm, ex_rd, ex_we, wb_rd, wb_we, id_freeze, ex_freeze
		// Unwritten registers read zero, then writes read back through the file
		rows.push_back(row_t'{5'd20, 5'd21, 1'b0, 5'd0, 1'b0, 5'd1,  1'b1, 1'b0, 1'b0});
		rows.push_back(row_t'{5'd1,  5'd22, 1'b0, 5'd0, 1'b0, 5'd2,  1'b1, 1'b0, 1'b0});
		rows.push_back(row_t'{5'd2,  5'd1,  1'b0, 5'd0, 1'b0, 5'd3,  1'b1, 1'b0, 1'b0});
		rows.push_back(row_t'{5'd3,  5'd2,  1'b0, 5'd0, 1'b0, 5'd4,  1'b1, 1'b0, 1'b0});
		rows.push_back(row_t'{5'd4,  5'd3,  1'b0, 5'd0, 1'b0, 5'd0,  1'b0, 1'b0, 1'b0});
		// Forwarding priority, immediate last
		rows.push_back(row_t'{5'd5,  5'd5,  1'b0, 5'd5, 1'b1, 5'd5,  1'b1, 1'b0, 1'b0});
		rows.push_back(row_t'{5'd7,  5'd6,  1'b0, 5'd6, 1'b1, 5'd7,  1'b1, 1'b0, 1'b0});
		rows.push_back(row_t'{5'd8,  5'd1,  1'b0, 5'd8, 1'b0, 5'd8,  1'b1, 1'b0, 1'b0});
		rows.push_back(row_t'{5'd9,  5'd9,  1'b1, 5'd9, 1'b1, 5'd0,  1'b0, 1'b0, 1'b0});
		rows.push_back(row_t'{5'd4,  5'd2,  1'b1, 5'd0, 1'b0, 5'd2,  1'b1, 1'b0, 1'b0});
		rows.push_back(row_t'{5'd7,  5'd8,  1'b0, 5'd0, 1'b0, 5'd0,  1'b0, 1'b0, 1'b0});
		// Execute freeze holds while sources change
		rows.push_back(row_t'{5'd1,  5'd2,  1'b0, 5'd1, 1'b1, 5'd2,  1'b1, 1'b0, 1'b1});
		rows.push_back(row_t'{5'd3,  5'd4,  1'b0, 5'd0, 1'b0, 5'd3,  1'b1, 1'b0, 1'b1});
		rows.push_back(row_t'{5'd5,  5'd6,  1'b1, 5'd5, 1'b1, 5'd0,  1'b0, 1'b0, 1'b1});
		rows.push_back(row_t'{5'd3,  5'd4,  1'b0, 5'd0, 1'b0, 5'd0,  1'b0, 1'b0, 1'b0});
		// Decode freeze captures once, then holds
		rows.push_back(row_t'{5'd1,  5'd2,  1'b0, 5'd0, 1'b0, 5'd10, 1'b1, 1'b1, 1'b0});
		rows.push_back(row_t'{5'd10, 5'd3,  1'b0, 5'd0, 1'b0, 5'd0,  1'b0, 1'b1, 1'b0});
		rows.push_back(row_t'{5'd4,  5'd5,  1'b0, 5'd4, 1'b1, 5'd0,  1'b0, 1'b1, 1'b1});
		rows.push_back(row_t'{5'd6,  5'd7,  1'b0, 5'd0, 1'b0, 5'd0,  1'b0, 1'b1, 1'b0});
		// First unfrozen row only returns to tracking, the next loads
		rows.push_back(row_t'{5'd10, 5'd1,  1'b0, 5'd0, 1'b0, 5'd0,  1'b0, 1'b0, 1'b0});
		rows.push_back(row_t'{5'd10, 5'd1,  1'b0, 5'd0, 1'b0, 5'd0,  1'b0, 1'b0, 1'b0});
		rows.push_back(row_t'{5'd2,  5'd3,  1'b1, 5'd2, 1'b1, 5'd3,  1'b1, 1'b0, 1'b0});
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;
		lfsr  = 32'd40;
		apply_row('0);
		for (int i = 0; i < `RF_DEPTH; i++) begin
			model_rf[i] = '0;
		end
		exp_a       = '0;
		exp_b       = '0;
		model_saved = 1'b0;
		load_table();

		// Ten cycles of reset, operands must come out zero
		for (int i = 0; i < 10; i++) begin
			wait_edge();
		end
		check_operands();
		#1;
		rst_n = 1'b1;

		// Drive at edge + 2 ns, check at the following edge + 1 ns
		for (int i = 0; i < rows.size(); i++) begin
			apply_row(rows[i]);
			model_step();
			wait_edge();
			check_operands();
			#1;
		end

		$display("Checks run: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, u_dut.u_operand_muxes.u_asserts.fail_count);
		if (errors == 0 && u_dut.u_operand_muxes.u_asserts.fail_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- operand_stage.f
+incdir+rtl
rtl/fwd_pkg.sv
rtl/pipe_pkg.sv
rtl/reg_file.sv
rtl/forward_ctrl.sv
rtl/operand_muxes.sv
rtl/operand_stage.sv
tb/operand_stage_asserts.sv
tb/operand_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f operand_stage.f \
	--top-module operand_stage_tb \
	-o operand_stage_sim \
	&& { ./obj_dir/operand_stage_sim > sim.log 2>&1; cat sim.log; } \
	|| { echo "run_sim: build failed"; exit 1; }

grep -q "ALL TESTS PASSED" sim.log \
	&& { echo "run_sim: simulation passed"; exit 0; } \
	|| { echo "run_sim: simulation failed, see sim.log"; exit 1; }
